/* flist.f */
src/core_pkg.sv
src/core_csr_if.sv
src/core_trap_if.sv
src/core_pipe_wb.sv
src/core_csrs.sv
src/core_regfile.sv
src/core_wb_top.sv
dv/tb_core_wb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_core_wb
FLIST     := flist.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir

/* dv/tb_core_wb.sv */
// Writeback subsystem testbench

`timescale 1ns/10ps

module tb_core_wb;
    import core_pkg::*;

    localparam int          TIMEOUT_CYCLES = 4000;      // 200 instrs at worst cost plus margin
    localparam logic [11:0] CSR_UNKNOWN    = 12'h7C0;   // Not implemented by the CSR block

    logic                  g_clk = 1'b0;
    logic                  g_resetn;
    logic                  s3_valid;
    logic                  s3_ready;
    logic [XLEN-1:0]       s3_pc;
    logic [31:0]           s3_instr;
    logic [XLEN-1:0]       s3_wdata;
    logic [REG_ADDR_W-1:0] s3_rd;
    wb_op_t                s3_wb_op;
    lsu_op_t               s3_lsu_op;
    csr_op_t               s3_csr_op;
    logic [11:0]           s3_csr_addr;
    cfu_op_t               s3_cfu_op;
    logic                  s3_trap;
    logic [XLEN-1:0]       s3_dmem_rdata;
    logic                  s3_cf_valid;
    logic                  s3_cf_ack;
    logic [XLEN-1:0]       s3_cf_target;
    logic                  trs_valid;
    logic [XLEN-1:0]       trs_pc;
    logic [31:0]           trs_instr;
    logic                  irq;
    logic                  int_ack;
    logic [REG_ADDR_W-1:0] rs_addr;
    logic [XLEN-1:0]       rs_rdata;

    // Reference model
    // ------------------------------
    logic [XLEN-1:0] gpr_model [0:31];
    logic            m_mie;
    logic            m_mpie;
    logic [XLEN-1:0] m_mtvec;
    logic [XLEN-1:0] m_mscratch;
    logic [XLEN-1:0] m_mepc;
    logic [XLEN-1:0] m_mcause;
    logic [XLEN-1:0] retired;                      // Expected minstret
    logic [XLEN-1:0] pc_next;
    logic [XLEN-1:0] exp_pc_q [$];                 // Trace still to come
    logic [31:0]     exp_instr_q [$];
    string           test_name = "reset";
    int              cycle_count = 0;

    core_wb_top i_dut (.*);

    always #5 g_clk = ~g_clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] act);
        assert (act === exp) else begin
            stop_run($sformatf("Fail %s: %s expected %h actual %h", test_name, what, exp, act));
        end
    endtask

    // Outputs are sampled on the rising edge, inputs move on the falling edge
    always @(posedge g_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_run("Timeout: the run did not finish within the cycle limit");
        end else if (g_resetn && trs_valid) begin
            if (exp_pc_q.size() == 0) begin
                stop_run("Trace pulse seen with no retiring instruction expected");
            end else begin
                check_value("trace pc", exp_pc_q.pop_front(), trs_pc);
                check_value("trace instr", XLEN'(exp_instr_q.pop_front()), XLEN'(trs_instr));
            end
        end
    end

    // A change waiting for ack freezes the stage
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        s3_cf_valid && !s3_cf_ack |-> !s3_ready && !trs_valid && !int_ack)
        else stop_run("Stage moved on while a control flow change waited for ack");

    assert property (@(posedge g_clk) disable iff (!g_resetn)
        s3_cf_valid && !s3_cf_ack |=> s3_cf_valid && $stable(s3_cf_target))
        else stop_run("Control flow change dropped or its target moved before ack");

    function automatic logic [XLEN-1:0] rand64();
        return {$urandom, $urandom};
    endfunction

    // Shift by the byte offset, keep the access width, then extend
    function automatic logic [XLEN-1:0] expect_load(input lsu_op_t op,
                                                    input logic [XLEN-1:0] raw,
                                                    input logic [2:0] off);
        logic [XLEN-1:0] shifted;
        logic [XLEN-1:0] mask;
        logic [XLEN-1:0] value;
        int              bytes;
        shifted = raw >> (8 * off);
        case (op)
            LSU_LB, LSU_LBU: bytes = 1;
            LSU_LH, LSU_LHU: bytes = 2;
            LSU_LW, LSU_LWU: bytes = 4;
            default:         bytes = 8;
        endcase
        mask  = (bytes == 8) ? '1 : ((64'd1 << (8 * bytes)) - 64'd1);
        value = shifted & mask;
        if ((op inside {LSU_LB, LSU_LH, LSU_LW}) && shifted[8 * bytes - 1]) begin
            value = value | ~mask;
        end
        return value;
    endfunction

    function automatic logic [XLEN-1:0] csr_model_read(input logic [11:0] addr);
        case (addr)
            CSR_MSTATUS:  return {56'd0, m_mpie, 3'b000, m_mie, 3'b000};
            CSR_MTVEC:    return m_mtvec;
            CSR_MSCRATCH: return m_mscratch;
            CSR_MEPC:     return m_mepc;
            CSR_MCAUSE:   return m_mcause;
            CSR_MINSTRET: return retired;
            default:      return '0;
        endcase
    endfunction

    task automatic csr_model_write(input logic [11:0] addr, input logic [XLEN-1:0] value);
        case (addr)
            CSR_MSTATUS: begin
                m_mie  = value[3];
                m_mpie = value[7];
            end
            CSR_MTVEC:    m_mtvec    = value;
            CSR_MSCRATCH: m_mscratch = value;
            CSR_MEPC:     m_mepc     = value;
            CSR_MCAUSE:   m_mcause   = value;
            default: ;
        endcase
    endtask

    task automatic take_trap(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] cause);
        m_mepc   = pc;
        m_mcause = cause;
        m_mpie   = m_mie;
        m_mie    = 1'b0;
    endtask

    // Stimulus helpers, all start and end on a falling edge
    // ------------------------------
    task automatic clear_payload();
        s3_pc         = pc_next;
        pc_next       = pc_next + 64'd4;
        s3_instr      = $urandom;
        s3_wdata      = '0;
        s3_rd         = '0;
        s3_wb_op      = WB_NONE;
        s3_lsu_op     = LSU_NONE;
        s3_csr_op     = CSR_NONE;
        s3_csr_addr   = '0;
        s3_cfu_op     = CFU_NONE;
        s3_trap       = 1'b0;
        s3_dmem_rdata = '0;
    endtask

    task automatic expect_trace();
        exp_pc_q.push_back(s3_pc);
        exp_instr_q.push_back(s3_instr);
        retired = retired + 64'd1;
    endtask

    task automatic alu_payload(input logic [4:0] rd, input logic retires);
        clear_payload();
        s3_wb_op = WB_WDATA;
        s3_rd    = rd;
        s3_wdata = rand64();
        if (retires) expect_trace();
    endtask

    // Offer the payload, wait for accept, then see it complete or trap
    task automatic issue(input logic cf_exp, input logic [XLEN-1:0] target_exp,
                         input logic int_exp, input logic irq_level);
        int hold;
        s3_valid = 1'b1;
        @(posedge g_clk);
        while (!s3_ready) @(posedge g_clk);
        @(negedge g_clk);
        s3_valid = 1'b0;
        irq      = irq_level;                      // Instruction now sits in the stage
        if (cf_exp) begin
            hold = $urandom_range(1, 5);
            repeat (hold) begin
                @(posedge g_clk);
                check_value("cf_valid before ack", 64'd1, XLEN'(s3_cf_valid));
                check_value("cf_target before ack", target_exp, s3_cf_target);
            end
            @(negedge g_clk);
            s3_cf_ack = 1'b1;
            irq       = 1'b0;                      // Pending change keeps its interrupt
            @(posedge g_clk);
            check_value("cf_target at ack", target_exp, s3_cf_target);
            check_value("int_ack at ack", XLEN'(int_exp), XLEN'(int_ack));
            @(negedge g_clk);
            s3_cf_ack = 1'b0;
        end else begin
            @(posedge g_clk);
            check_value("cf_valid", 64'd0, XLEN'(s3_cf_valid));
            check_value("s3_ready at completion", 64'd1, XLEN'(s3_ready));
            @(negedge g_clk);
        end
        irq = 1'b0;
    endtask

    task automatic check_gpr(input logic [4:0] idx);
        rs_addr = idx;
        @(posedge g_clk);
        check_value($sformatf("x%0d", idx), gpr_model[idx], rs_rdata);
        @(negedge g_clk);
    endtask

    // CSR result lands in rd as the old value
    task automatic access_csr(input csr_op_t op, input logic [11:0] addr,
                              input logic [XLEN-1:0] operand, input logic [4:0] rd);
        logic [XLEN-1:0] old_val;
        old_val = csr_model_read(addr);
        clear_payload();
        s3_wb_op    = WB_CSR;
        s3_csr_op   = op;
        s3_csr_addr = addr;
        s3_wdata    = operand;
        s3_rd       = rd;
        expect_trace();
        issue(1'b0, '0, 1'b0, 1'b0);
        if (rd != 5'd0) gpr_model[rd] = old_val;
        case (op)
            CSR_RW:  csr_model_write(addr, operand);
            CSR_RS:  csr_model_write(addr, old_val | operand);
            CSR_RC:  csr_model_write(addr, old_val & ~operand);
            default: ;
        endcase
        check_gpr(rd);
    endtask

    // Tests
    // ------------------------------
    task automatic alu_writeback();
        test_name = "alu_writeback";
        for (int i = 0; i < 40; i++) begin
            alu_payload(5'((i * 7) % 32), 1'b1); // Walks every register
            if (s3_rd != 5'd0) gpr_model[s3_rd] = s3_wdata;
            s3_valid = 1'b1;
            @(posedge g_clk);
            check_value("s3_ready back to back", 64'd1, XLEN'(s3_ready));
            @(negedge g_clk);
        end
        s3_valid = 1'b0;
        @(posedge g_clk);                          // Last one writes here
        @(negedge g_clk);
        for (int r = 0; r < 32; r++) check_gpr(5'(r));
    endtask

    task automatic load_format();
        logic [XLEN-1:0] raw;
        logic [2:0]      off;
        test_name = "load_format";
        for (int k = 1; k < 8; k++) begin
            for (int rep = 0; rep < 3; rep++) begin
                raw = rand64();
                off = 3'($urandom);
                clear_payload();
                s3_wb_op      = WB_LSU;
                s3_lsu_op     = lsu_op_t'(k);
                s3_rd         = 5'(15 + k);
                s3_dmem_rdata = raw;
                s3_wdata      = (rand64() & ~64'd7) | XLEN'(off);
                expect_trace();
                issue(1'b0, '0, 1'b0, 1'b0);
                gpr_model[s3_rd] = expect_load(lsu_op_t'(k), raw, off);
                check_gpr(s3_rd);
            end
        end
    endtask

    task automatic csr_rmw(input logic [11:0] addr);
        test_name = "csr_access";
        access_csr(CSR_RW, addr, rand64() & ~64'd3, 5'd1);
        access_csr(CSR_RD, addr, '0, 5'd2);
        access_csr(CSR_RS, addr, rand64() & ~64'd3, 5'd3);
        access_csr(CSR_RD, addr, '0, 5'd2);
        access_csr(CSR_RC, addr, rand64(), 5'd4);
        access_csr(CSR_RD, addr, '0, 5'd2);
    endtask

    task automatic trap_entry();
        logic [XLEN-1:0] trap_pc;
        test_name = "trap";
        alu_payload(5'd5, 1'b0);
        s3_trap = 1'b1;
        trap_pc = s3_pc;
        issue(1'b1, m_mtvec, 1'b0, 1'b0);
        take_trap(trap_pc, CAUSE_ILLEGAL_INSTR);
        check_gpr(5'd5);                           // rd left alone
        access_csr(CSR_RD, CSR_MEPC, '0, 5'd6);
        access_csr(CSR_RD, CSR_MCAUSE, '0, 5'd7);
        test_name = "csr_error";
        clear_payload();
        s3_wb_op    = WB_CSR;
        s3_csr_op   = CSR_RW;
        s3_csr_addr = CSR_UNKNOWN;
        s3_rd       = 5'd8;
        s3_wdata    = rand64();
        trap_pc     = s3_pc;
        issue(1'b1, m_mtvec, 1'b0, 1'b0);
        take_trap(trap_pc, CAUSE_ILLEGAL_INSTR);
        check_gpr(5'd8);
        access_csr(CSR_RD, CSR_MEPC, '0, 5'd6);
        access_csr(CSR_RD, CSR_MCAUSE, '0, 5'd7);
    endtask

    task automatic interrupt_mret();
        logic [XLEN-1:0] int_pc;
        test_name = "interrupt";
        access_csr(CSR_RS, CSR_MSTATUS, 64'h8, 5'd9);
        alu_payload(5'd10, 1'b0);                  // Discarded by the interrupt
        int_pc = s3_pc;
        issue(1'b1, m_mtvec, 1'b1, 1'b1);
        take_trap(int_pc, CAUSE_M_EXT_INT);
        check_gpr(5'd10);
        access_csr(CSR_RD, CSR_MCAUSE, '0, 5'd11);
        access_csr(CSR_RD, CSR_MEPC, '0, 5'd11);
        test_name = "mret";
        clear_payload();
        s3_cfu_op = CFU_MRET;
        expect_trace();
        issue(1'b1, m_mepc, 1'b0, 1'b0);
        m_mie  = m_mpie;
        m_mpie = 1'b1;
        access_csr(CSR_RD, CSR_MSTATUS, '0, 5'd12);
        test_name = "irq_masked";
        access_csr(CSR_RC, CSR_MSTATUS, 64'h8, 5'd13);
        alu_payload(5'd14, 1'b1);
        issue(1'b0, '0, 1'b0, 1'b1);               // irq high, no change expected
        gpr_model[14] = s3_wdata;
        check_gpr(5'd14);
    endtask

    initial begin
        void'($urandom(25498));
        g_resetn   = 1'b0;
        s3_valid   = 1'b0;
        s3_cf_ack  = 1'b0;
        irq        = 1'b0;
        rs_addr    = '0;
        pc_next    = 64'h0000_0000_8000_0000;
        m_mie      = 1'b0;
        m_mpie     = 1'b0;
        m_mtvec    = '0;
        m_mscratch = '0;
        m_mepc     = '0;
        m_mcause   = '0;
        retired    = '0;
        for (int r = 0; r < 32; r++) gpr_model[r] = '0;
        clear_payload();
        repeat (3) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;

        alu_writeback();
        load_format();
        csr_rmw(CSR_MTVEC);
        csr_rmw(CSR_MSCRATCH);
        access_csr(CSR_RW, CSR_MTVEC, 64'h0000_0000_8000_0100, 5'd1); // Known trap vector
        access_csr(CSR_RD, CSR_MINSTRET, '0, 5'd5);
        trap_entry();
        interrupt_mret();

        test_name = "end";
        if (exp_pc_q.size() == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            stop_run("Some retiring instructions gave no trace pulse");
        end
    end

endmodule

/* src/core_wb_top.sv */
// Writeback subsystem top
// Stage, CSR block and register file

`timescale 1ns/10ps

module core_wb_top (
    input  logic                            g_clk,
    input  logic                            g_resetn,
    input  logic                            s3_valid,
    output logic                            s3_ready,
    input  logic [core_pkg::XLEN-1:0]       s3_pc,
    input  logic [31:0]                     s3_instr,
    input  logic [core_pkg::XLEN-1:0]       s3_wdata,
    input  logic [core_pkg::REG_ADDR_W-1:0] s3_rd,
    input  core_pkg::wb_op_t                s3_wb_op,
    input  core_pkg::lsu_op_t               s3_lsu_op,
    input  core_pkg::csr_op_t               s3_csr_op,
    input  logic [11:0]                     s3_csr_addr,
    input  core_pkg::cfu_op_t               s3_cfu_op,
    input  logic                            s3_trap,
    input  logic [core_pkg::XLEN-1:0]       s3_dmem_rdata,
    output logic                            s3_cf_valid,
    input  logic                            s3_cf_ack,
    output logic [core_pkg::XLEN-1:0]       s3_cf_target,
    output logic                            trs_valid,
    output logic [core_pkg::XLEN-1:0]       trs_pc,
    output logic [31:0]                     trs_instr,
    input  logic                            irq,
    output logic                            int_ack,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs_addr,     // Front of pipe read
    output logic [core_pkg::XLEN-1:0]       rs_rdata
);

    logic                            rd_wen;
    logic [core_pkg::REG_ADDR_W-1:0] rd_addr;
    logic [core_pkg::XLEN-1:0]       rd_wdata;

    core_csr_if  csr_bus ();
    core_trap_if trap_bus ();

    core_pipe_wb i_core_pipe_wb (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .s3_valid      (s3_valid),
        .s3_ready      (s3_ready),
        .s3_pc         (s3_pc),
        .s3_instr      (s3_instr),
        .s3_wdata      (s3_wdata),
        .s3_rd         (s3_rd),
        .s3_wb_op      (s3_wb_op),
        .s3_lsu_op     (s3_lsu_op),
        .s3_csr_op     (s3_csr_op),
        .s3_csr_addr   (s3_csr_addr),
        .s3_cfu_op     (s3_cfu_op),
        .s3_trap       (s3_trap),
        .s3_dmem_rdata (s3_dmem_rdata),
        .s3_cf_valid   (s3_cf_valid),
        .s3_cf_ack     (s3_cf_ack),
        .s3_cf_target  (s3_cf_target),
        .rd_wen        (rd_wen),
        .rd_addr       (rd_addr),
        .rd_wdata      (rd_wdata),
        .int_ack       (int_ack),
        .csr           (csr_bus.wb),
        .trp           (trap_bus.wb),
        .trs_valid     (trs_valid),
        .trs_pc        (trs_pc),
        .trs_instr     (trs_instr)
    );

    core_csrs i_core_csrs (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .irq      (irq),
        .csr      (csr_bus.csrs),
        .trp      (trap_bus.csrs)
    );

    core_regfile i_core_regfile (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .wen      (rd_wen),
        .waddr    (rd_addr),
        .wdata    (rd_wdata),
        .raddr    (rs_addr),
        .rdata    (rs_rdata)
    );

endmodule

/* src/core_regfile.sv */
// General purpose register file

`timescale 1ns/10ps

module core_regfile (
    input  logic                            g_clk,
    input  logic                            g_resetn,
    input  logic                            wen,
    input  logic [core_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [core_pkg::XLEN-1:0]       wdata,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr,
    output logic [core_pkg::XLEN-1:0]       rdata
);
    import core_pkg::*;

    logic [XLEN-1:0] regs [1:31];                 // x0 has no storage

    // Writes are held off while reset is asserted
    always_ff @(posedge g_clk) begin
        if (g_resetn && wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // No write bypass
    assign rdata = (raddr == '0) ? '0 : regs[raddr];

endmodule

/* src/core_csrs.sv */
// Machine mode CSR block

`timescale 1ns/10ps

module core_csrs (
    input  logic      g_clk,
    input  logic      g_resetn,
    input  logic      irq,                        // External interrupt line
    core_csr_if.csrs  csr,
    core_trap_if.csrs trp
);
    import core_pkg::*;

    logic            mie;                         // mstatus.MIE
    logic            mpie;                        // mstatus.MPIE
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mtval;
    logic [XLEN-1:0] minstret;

    logic [XLEN-1:0] mstatus_rd;
    logic            bad_addr;
    logic            do_write;
    logic [XLEN-1:0] new_val;

    assign mstatus_rd = {{(XLEN-8){1'b0}}, mpie, 3'b000, mie, 3'b000};

    // Read port
    // ------------------------------
    always_comb begin
        bad_addr = 1'b0;
        case (csr.addr)
            CSR_MSTATUS:  csr.rdata = mstatus_rd;
            CSR_MTVEC:    csr.rdata = mtvec;
            CSR_MSCRATCH: csr.rdata = mscratch;
            CSR_MEPC:     csr.rdata = mepc;
            CSR_MCAUSE:   csr.rdata = mcause;
            CSR_MTVAL:    csr.rdata = mtval;
            CSR_MINSTRET: csr.rdata = minstret;
            default: begin
                csr.rdata = '0;
                bad_addr  = 1'b1;
            end
        endcase
    end

    // minstret is read only here
    assign csr.error = bad_addr ||
                       (csr.addr == CSR_MINSTRET && (csr.wr || csr.set || csr.clr));

    assign do_write = csr.en && !csr.error && (csr.wr || csr.set || csr.clr);
    assign new_val  = csr.wr  ? csr.wdata :
                      csr.set ? (csr.rdata | csr.wdata) :
                                (csr.rdata & ~csr.wdata);

    // State update
    // ------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mie      <= 1'b0;
            mpie     <= 1'b0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            minstret <= '0;
        end else begin
            if (trp.trap || trp.take_int) begin
                mepc   <= trp.pc;
                mcause <= trp.cause;
                mtval  <= '0;                     // No faulting value kept
                mpie   <= mie;
                mie    <= 1'b0;
            end else if (trp.mret) begin
                mie  <= mpie;
                mpie <= 1'b1;
            end else if (do_write) begin
                case (csr.addr)
                    CSR_MSTATUS: begin
                        mie  <= new_val[3];
                        mpie <= new_val[7];
                    end
                    CSR_MTVEC:    mtvec    <= {new_val[XLEN-1:2], 2'b00}; // Direct mode
                    CSR_MSCRATCH: mscratch <= new_val;
                    CSR_MEPC:     mepc     <= new_val;
                    CSR_MCAUSE:   mcause   <= new_val;
                    CSR_MTVAL:    mtval    <= new_val;
                    default: ;
                endcase
            end
            if (trp.retire) minstret <= minstret + XLEN'(1);
        end
    end

    assign trp.int_pending = irq && mie;
    assign trp.tvec        = mtvec;
    assign trp.epc         = mepc;

endmodule

/* src/core_pipe_wb.sv */
// Writeback stage

`timescale 1ns/10ps

module core_pipe_wb (
    input  logic                           g_clk,
    input  logic                           g_resetn,
    input  logic                           s3_valid,      // Instruction offered
    output logic                           s3_ready,      // Stage can take it
    input  logic [core_pkg::XLEN-1:0]      s3_pc,
    input  logic [31:0]                    s3_instr,
    input  logic [core_pkg::XLEN-1:0]      s3_wdata,      // ALU result or address
    input  logic [core_pkg::REG_ADDR_W-1:0] s3_rd,
    input  core_pkg::wb_op_t               s3_wb_op,
    input  core_pkg::lsu_op_t              s3_lsu_op,
    input  core_pkg::csr_op_t              s3_csr_op,
    input  logic [11:0]                    s3_csr_addr,
    input  core_pkg::cfu_op_t              s3_cfu_op,
    input  logic                           s3_trap,       // Decode raised a trap
    input  logic [core_pkg::XLEN-1:0]      s3_dmem_rdata, // Raw load doubleword
    output logic                           s3_cf_valid,
    input  logic                           s3_cf_ack,
    output logic [core_pkg::XLEN-1:0]      s3_cf_target,
    output logic                           rd_wen,
    output logic [core_pkg::REG_ADDR_W-1:0] rd_addr,
    output logic [core_pkg::XLEN-1:0]      rd_wdata,
    output logic                           int_ack,
    core_csr_if.wb                         csr,
    core_trap_if.wb                        trp,
    output logic                           trs_valid,
    output logic [core_pkg::XLEN-1:0]      trs_pc,
    output logic [31:0]                    trs_instr
);
    import core_pkg::*;

    // Stage registers
    // ------------------------------
    logic                  full;
    logic                  hold_q;                // Change waiting for ack
    logic                  int_q;                 // Interrupt seen last cycle
    logic [XLEN-1:0]       pc_q;
    logic [31:0]           instr_q;
    logic [XLEN-1:0]       wdata_q;
    logic [REG_ADDR_W-1:0] rd_q;
    wb_op_t                wb_op_q;
    lsu_op_t               lsu_op_q;
    csr_op_t               csr_op_q;
    logic [11:0]           csr_addr_q;
    cfu_op_t               cfu_op_q;
    logic                  trap_q;
    logic [XLEN-1:0]       dmem_rdata_q;

    logic            complete;
    logic            raise_int;
    logic            has_csr;
    logic            csr_trap;
    logic            dec_trap;
    logic            trap_any;
    logic            is_mret;
    logic            cf_fire;
    logic [5:0]      lsu_shift;
    logic [XLEN-1:0] lsu_shifted;
    logic [XLEN-1:0] lsu_rdata;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            full   <= 1'b0;
            hold_q <= 1'b0;
            int_q  <= 1'b0;
        end else begin
            if (s3_ready) full <= s3_valid;           // Fill, refill or drain
            hold_q <= s3_cf_valid && !s3_cf_ack;
            int_q  <= raise_int;
        end
    end

    always_ff @(posedge g_clk) begin
        if (s3_valid && s3_ready) begin
            pc_q         <= s3_pc;
            instr_q      <= s3_instr;
            wdata_q      <= s3_wdata;
            rd_q         <= s3_rd;
            wb_op_q      <= s3_wb_op;
            lsu_op_q     <= s3_lsu_op;
            csr_op_q     <= s3_csr_op;
            csr_addr_q   <= s3_csr_addr;
            cfu_op_q     <= s3_cfu_op;
            trap_q       <= s3_trap;
            dmem_rdata_q <= s3_dmem_rdata;
        end
    end

    // Control flow and traps
    // ------------------------------
    // Interrupt decision is frozen while a change waits for its ack
    assign raise_int = full && (hold_q ? int_q : trp.int_pending);
    assign has_csr   = csr_op_q != CSR_NONE;
    assign csr_trap  = has_csr && csr.error;
    assign dec_trap  = full && (trap_q || csr_trap);
    assign trap_any  = raise_int || dec_trap;
    assign is_mret   = full && cfu_op_q == CFU_MRET;

    assign s3_cf_valid  = trap_any || is_mret;
    assign s3_cf_target = trap_any ? trp.tvec : trp.epc;
    assign cf_fire      = s3_cf_valid && s3_cf_ack;

    assign complete = full && (!s3_cf_valid || s3_cf_ack);
    assign s3_ready = !full || complete;

    assign int_ack      = raise_int && cf_fire;
    assign trp.take_int = int_ack;
    assign trp.trap     = dec_trap && !raise_int && cf_fire;
    assign trp.mret     = is_mret && !trap_any && cf_fire;
    assign trp.retire   = complete && !trap_any;
    assign trp.cause    = raise_int ? CAUSE_M_EXT_INT : CAUSE_ILLEGAL_INSTR;
    assign trp.pc       = pc_q;

    // CSR request
    // ------------------------------
    assign csr.en    = full && has_csr && !s3_cf_valid; // Only when it completes
    assign csr.wr    = csr_op_q == CSR_RW;
    assign csr.set   = csr_op_q == CSR_RS;
    assign csr.clr   = csr_op_q == CSR_RC;
    assign csr.addr  = csr_addr_q;
    assign csr.wdata = wdata_q;

    // Load formatting
    // ------------------------------
    assign lsu_shift   = {wdata_q[2:0], 3'b000};  // Byte offset in bits
    assign lsu_shifted = dmem_rdata_q >> lsu_shift;

    always_comb begin
        case (lsu_op_q)
            LSU_LB:  lsu_rdata = {{56{lsu_shifted[7]}}, lsu_shifted[7:0]};
            LSU_LBU: lsu_rdata = {56'd0, lsu_shifted[7:0]};
            LSU_LH:  lsu_rdata = {{48{lsu_shifted[15]}}, lsu_shifted[15:0]};
            LSU_LHU: lsu_rdata = {48'd0, lsu_shifted[15:0]};
            LSU_LW:  lsu_rdata = {{32{lsu_shifted[31]}}, lsu_shifted[31:0]};
            LSU_LWU: lsu_rdata = {32'd0, lsu_shifted[31:0]};
            default: lsu_rdata = lsu_shifted;      // LD and no-op pass through
        endcase
    end

    // GPR writeback
    // ------------------------------
    assign rd_wen  = trp.retire && wb_op_q != WB_NONE;
    assign rd_addr = rd_q;

    always_comb begin
        case (wb_op_q)
            WB_WDATA: rd_wdata = wdata_q;
            WB_LSU:   rd_wdata = lsu_rdata;
            WB_CSR:   rd_wdata = csr.rdata;         // Old CSR value
            default:  rd_wdata = '0;
        endcase
    end

    // Trace
    assign trs_valid = trp.retire;
    assign trs_pc    = pc_q;
    assign trs_instr = instr_q;

endmodule

/* src/core_trap_if.sv */
// Trap and retire event bus

`timescale 1ns/10ps

interface core_trap_if;
    import core_pkg::*;

    logic            trap;                       // Synchronous trap taken
    logic            take_int;                   // Interrupt taken
    logic [XLEN-1:0] cause;
    logic [XLEN-1:0] pc;                         // Saved into mepc
    logic            mret;
    logic            retire;                     // One instruction done
    logic            int_pending;                // Gated by MIE
    logic [XLEN-1:0] tvec;
    logic [XLEN-1:0] epc;

    modport wb (
        output trap, take_int, cause, pc, mret, retire,
        input  int_pending, tvec, epc
    );

    modport csrs (
        input  trap, take_int, cause, pc, mret, retire,
        output int_pending, tvec, epc
    );

endinterface

/* src/core_csr_if.sv */
// CSR access bus

`timescale 1ns/10ps

interface core_csr_if;
    import core_pkg::*;

    logic            en;                         // Access strobe
    logic            wr;                         // Plain write
    logic            set;                        // Bit set write
    logic            clr;                        // Bit clear write
    logic [11:0]     addr;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] rdata;                      // Same cycle read value
    logic            error;                      // Bad address or read-only

    modport wb (
        output en, wr, set, clr, addr, wdata,
        input  rdata, error
    );

    modport csrs (
        input  en, wr, set, clr, addr, wdata,
        output rdata, error
    );

endinterface

/* src/core_pkg.sv */
// Writeback subsystem shared definitions

package core_pkg;

    // Widths
    // ------------------------------
    localparam int XLEN       = 64;              // Data path width
    localparam int REG_ADDR_W = 5;               // GPR index width

    // Writeback data source
    typedef enum logic [1:0] {
        WB_NONE,                                 // No GPR write
        WB_WDATA,                                // ALU result
        WB_LSU,                                  // Formatted load data
        WB_CSR                                   // CSR read value
    } wb_op_t;

    // Load type, sign handling is per op
    typedef enum logic [2:0] {
        LSU_NONE,
        LSU_LB,
        LSU_LBU,
        LSU_LH,
        LSU_LHU,
        LSU_LW,
        LSU_LWU,
        LSU_LD
    } lsu_op_t;

    typedef enum logic [2:0] {
        CSR_NONE,
        CSR_RD,                                  // Read only
        CSR_RW,                                  // Swap
        CSR_RS,                                  // Read then set bits
        CSR_RC                                   // Read then clear bits
    } csr_op_t;

    typedef enum logic [0:0] {
        CFU_NONE,
        CFU_MRET
    } cfu_op_t;

    // Machine CSR addresses
    // ------------------------------
    localparam logic [11:0] CSR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;
    localparam logic [11:0] CSR_MTVAL    = 12'h343;
    localparam logic [11:0] CSR_MINSTRET = 12'hB02;

    // Trap causes, top bit marks an interrupt
    localparam logic [XLEN-1:0] CAUSE_ILLEGAL_INSTR = 64'd2;
    localparam logic [XLEN-1:0] CAUSE_M_EXT_INT     = {1'b1, 63'd11};

endpackage
